/* rvPipePkg.sv */
// Widths, opcodes, ALU codes, instruction views, immediate helpers and stage structs
package rvPipePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [XLEN-1:0] RESET_PC = '0;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } aluOpE;

    // One instruction word seen in five field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instWordU;

    // Shared by fetch prediction and decode
    function automatic logic [XLEN-1:0] immB(instWordU w);
        return {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] immJ(instWordU w);
        return {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
    endfunction

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  linkWrite; // rd gets pc+4
        logic  aluSrcImm;
        aluOpE aluOp;
        logic  branch;
        logic  jump;
        logic  bne;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
        logic            bPred;
        logic            bPredValid;
    } ifIdT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       rData1;
        logic [XLEN-1:0]       rData2;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic                  bPred;
        logic                  bPredValid;
    } idExT;

    typedef struct packed {
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  memToReg;
        logic                  linkWrite;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       storeData;
        logic [XLEN-1:0]       linkData;
    } exMemT;

    typedef struct packed {
        logic                  regWrite;
        logic                  memToReg;
        logic                  linkWrite;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       aluResult;
        logic [XLEN-1:0]       loadData;
        logic [XLEN-1:0]       linkData;
    } memWbT;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wbT;

endpackage

/* pipeRegs.sv */
// IF/ID and ID/EX stage registers with stall and flush
`timescale 1ns/1ps

module ifIdReg (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  rvPipePkg::ifIdT in,
    output rvPipePkg::ifIdT out
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out <= '{
                inst:       rvPipePkg::NOP_INST,
                pc:         rvPipePkg::RESET_PC,
                bPred:      1'b0,
                bPredValid: 1'b0
            };
        end else if (flush) begin
            // Squash to NOP and drop the prediction
            out <= '{
                inst:       rvPipePkg::NOP_INST,
                pc:         in.pc,
                bPred:      1'b0,
                bPredValid: 1'b0
            };
        end else if (!stall) begin
            out <= in;
        end
    end

endmodule

module idExReg (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  rvPipePkg::idExT in,
    output rvPipePkg::idExT out
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out <= '0;
        end else if (flush) begin
            out <= '0; // Bubble
        end else begin
            out <= in;
        end
    end

endmodule

/* fetchUnit.sv */
// Program counter with static backward-taken prediction and redirect
`timescale 1ns/1ps

module fetchUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic                       redirectValid,
    input  logic [rvPipePkg::XLEN-1:0] redirectPc,
    output logic [rvPipePkg::XLEN-1:0] imemAddr,
    input  logic [rvPipePkg::XLEN-1:0] imemData,
    output rvPipePkg::ifIdT            out
);

    logic [rvPipePkg::XLEN-1:0] pc;
    logic [rvPipePkg::XLEN-1:0] nextPc;
    logic [rvPipePkg::XLEN-1:0] predTarget;
    rvPipePkg::instWordU        word;
    logic                       isBranch;
    logic                       isJal;
    logic                       predTaken;

    assign word     = imemData;
    assign imemAddr = pc;

    assign isBranch  = word.r.opcode == rvPipePkg::OPC_BRANCH;
    assign isJal     = word.r.opcode == rvPipePkg::OPC_JAL;
    assign predTaken = isJal || (isBranch && word.b.imm12); // Sign bit set means backward

    assign predTarget = pc + (isJal ? rvPipePkg::immJ(word) : rvPipePkg::immB(word));

    always_comb begin
        if (redirectValid)
            nextPc = redirectPc;
        else if (stall)
            nextPc = pc;
        else if (predTaken)
            nextPc = predTarget;
        else
            nextPc = pc + 32'd4;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            pc <= rvPipePkg::RESET_PC;
        else
            pc <= nextPc;
    end

    assign out = '{
        inst:       imemData,
        pc:         pc,
        bPred:      predTaken,
        bPredValid: isBranch || isJal
    };

endmodule

/* decodeUnit.sv */
// Field extraction, control generation and immediate generation
`timescale 1ns/1ps

module decodeUnit (
    input  rvPipePkg::ifIdT                        in,
    output logic [rvPipePkg::REG_ADDR_W-1:0]       rs1,
    output logic [rvPipePkg::REG_ADDR_W-1:0]       rs2,
    input  logic [rvPipePkg::XLEN-1:0]             rData1,
    input  logic [rvPipePkg::XLEN-1:0]             rData2,
    output rvPipePkg::idExT                        out
);

    rvPipePkg::instWordU        inst;
    rvPipePkg::ctrlT            ctrl;
    logic [rvPipePkg::XLEN-1:0] imm;

    assign inst = in.inst;
    assign rs1  = inst.r.rs1;
    assign rs2  = inst.r.rs2;

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (inst.r.opcode)
            rvPipePkg::OPC_OP: begin
                ctrl.regWrite = 1'b1;
                case (inst.r.funct3)
                    3'b000:  ctrl.aluOp = inst.r.funct7[5] ? rvPipePkg::ALU_SUB
                                                           : rvPipePkg::ALU_ADD;
                    3'b010:  ctrl.aluOp = rvPipePkg::ALU_SLT;
                    3'b100:  ctrl.aluOp = rvPipePkg::ALU_XOR;
                    3'b110:  ctrl.aluOp = rvPipePkg::ALU_OR;
                    3'b111:  ctrl.aluOp = rvPipePkg::ALU_AND;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            rvPipePkg::OPC_OP_IMM: begin
                if (inst.i.funct3 == 3'b000) begin // ADDI only
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            rvPipePkg::OPC_LOAD: begin
                if (inst.i.funct3 == 3'b010) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.memRead   = 1'b1;
                    ctrl.memToReg  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            rvPipePkg::OPC_STORE: begin
                if (inst.s.funct3 == 3'b010) begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                imm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
            end
            rvPipePkg::OPC_BRANCH: begin
                if (inst.b.funct3[2:1] == 2'b00) begin // BEQ, BNE
                    ctrl.branch = 1'b1;
                    ctrl.bne    = inst.b.funct3[0];
                    ctrl.aluOp  = rvPipePkg::ALU_SUB;
                end
                imm = rvPipePkg::immB(inst);
            end
            rvPipePkg::OPC_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.linkWrite = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.aluOp     = rvPipePkg::ALU_PASSB;
                imm            = rvPipePkg::immJ(inst);
            end
            default: ;
        endcase
    end

    assign out = '{
        ctrl:       ctrl,
        rs1:        inst.r.rs1,
        rs2:        inst.r.rs2,
        rd:         inst.r.rd,
        funct3:     inst.r.funct3,
        rData1:     rData1,
        rData2:     rData2,
        imm:        imm,
        pc:         in.pc,
        bPred:      in.bPred,
        bPredValid: in.bPredValid
    };

endmodule

/* regFile.sv */
// 32 x 32 register file, write-first read ports, x0 tied to zero
`timescale 1ns/1ps

module regFile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [rvPipePkg::REG_ADDR_W-1:0]    rs1,
    input  logic [rvPipePkg::REG_ADDR_W-1:0]    rs2,
    output logic [rvPipePkg::XLEN-1:0]          rData1,
    output logic [rvPipePkg::XLEN-1:0]          rData2,
    input  rvPipePkg::wbT                       wb
);

    logic [rvPipePkg::XLEN-1:0] regs [1:2**rvPipePkg::REG_ADDR_W-1];

    function automatic logic [rvPipePkg::XLEN-1:0] readPort(
        logic [rvPipePkg::REG_ADDR_W-1:0] rs
    );
        if (rs == '0)
            return '0;
        if (wb.valid && wb.rd == rs)
            return wb.data; // Same-cycle write passes through
        return regs[rs];
    endfunction

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 2**rvPipePkg::REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        rData1 = readPort(rs1);
        rData2 = readPort(rs2);
    end

endmodule

/* hazardUnit.sv */
// Load-use stall detection merged with branch redirect flushes
`timescale 1ns/1ps

module hazardUnit (
    input  rvPipePkg::idExT                     idEx,
    input  logic [rvPipePkg::REG_ADDR_W-1:0]    rs1,
    input  logic [rvPipePkg::REG_ADDR_W-1:0]    rs2,
    input  logic                                redirectValid,
    output logic                                pcStall,
    output logic                                ifIdStall,
    output logic                                ifIdFlush,
    output logic                                idExFlush
);

    logic loadUse;

    // Load in EX whose result the decoding instruction needs
    assign loadUse = idEx.ctrl.memRead && idEx.rd != '0
                     && (idEx.rd == rs1 || idEx.rd == rs2);

    // Redirect wins over the stall
    assign pcStall   = loadUse && !redirectValid;
    assign ifIdStall = pcStall;
    assign ifIdFlush = redirectValid;
    assign idExFlush = redirectValid || loadUse; // Bubble or squash

endmodule

/* executeUnit.sv */
// Operand forwarding, ALU, branch resolution and EX/MEM register
`timescale 1ns/1ps

module executeUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  rvPipePkg::idExT            in,
    output rvPipePkg::exMemT           exMem,
    input  rvPipePkg::wbT              wb,
    output logic                       redirectValid,
    output logic [rvPipePkg::XLEN-1:0] redirectPc
);

    logic [rvPipePkg::XLEN-1:0] exMemValue;
    logic [rvPipePkg::XLEN-1:0] opA;
    logic [rvPipePkg::XLEN-1:0] fwdB;
    logic [rvPipePkg::XLEN-1:0] opB;
    logic [rvPipePkg::XLEN-1:0] aluResult;
    logic [rvPipePkg::XLEN-1:0] linkPc;
    logic                       taken;
    logic                       predTaken;

    assign exMemValue = exMem.linkWrite ? exMem.linkData : exMem.aluResult;

    // Youngest producer first
    function automatic logic [rvPipePkg::XLEN-1:0] forward(
        logic [rvPipePkg::REG_ADDR_W-1:0] rs,
        logic [rvPipePkg::XLEN-1:0]       regData
    );
        if (exMem.regWrite && exMem.rd != '0 && exMem.rd == rs)
            return exMemValue;
        if (wb.valid && wb.rd == rs)
            return wb.data;
        return regData;
    endfunction

    always_comb begin
        opA  = forward(in.rs1, in.rData1);
        fwdB = forward(in.rs2, in.rData2);
        opB  = in.ctrl.aluSrcImm ? in.imm : fwdB;
    end

    always_comb begin
        case (in.ctrl.aluOp)
            rvPipePkg::ALU_ADD:   aluResult = opA + opB;
            rvPipePkg::ALU_SUB:   aluResult = opA - opB;
            rvPipePkg::ALU_AND:   aluResult = opA & opB;
            rvPipePkg::ALU_OR:    aluResult = opA | opB;
            rvPipePkg::ALU_XOR:   aluResult = opA ^ opB;
            rvPipePkg::ALU_SLT:   aluResult = 32'($signed(opA) < $signed(opB));
            rvPipePkg::ALU_PASSB: aluResult = opB;
            default:              aluResult = '0;
        endcase
    end

    assign linkPc    = in.pc + 32'd4;
    assign taken     = in.ctrl.jump || (in.ctrl.branch && ((opA == fwdB) ^ in.ctrl.bne));
    assign predTaken = in.bPredValid && in.bPred;

    // Mispredict in either direction
    assign redirectValid = taken != predTaken;
    assign redirectPc    = taken ? in.pc + in.imm : linkPc;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            exMem <= '0;
        end else begin
            exMem <= '{
                regWrite:  in.ctrl.regWrite,
                memRead:   in.ctrl.memRead,
                memWrite:  in.ctrl.memWrite,
                memToReg:  in.ctrl.memToReg,
                linkWrite: in.ctrl.linkWrite,
                rd:        in.rd,
                aluResult: aluResult,
                storeData: fwdB,
                linkData:  linkPc
            };
        end
    end

endmodule

/* memWbStage.sv */
// Data memory, MEM/WB register and writeback select
`timescale 1ns/1ps

module memWbStage (
    input  logic             clk,
    input  logic             reset,
    input  rvPipePkg::exMemT in,
    output rvPipePkg::wbT    wb
);

    logic [rvPipePkg::XLEN-1:0]    dmem [rvPipePkg::DMEM_WORDS];
    logic [rvPipePkg::DMEM_AW-1:0] wordAddr;
    logic [rvPipePkg::XLEN-1:0]    loadData;
    rvPipePkg::memWbT              memWb;

    assign wordAddr = in.aluResult[rvPipePkg::DMEM_AW+1:2]; // Word aligned
    assign loadData = in.memRead ? dmem[wordAddr] : '0;

    always_ff @(posedge clk) begin
        if (in.memWrite)
            dmem[wordAddr] <= in.storeData;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            memWb <= '0;
        end else begin
            memWb <= '{
                regWrite:  in.regWrite,
                memToReg:  in.memToReg,
                linkWrite: in.linkWrite,
                rd:        in.rd,
                aluResult: in.aluResult,
                loadData:  loadData,
                linkData:  in.linkData
            };
        end
    end

    always_comb begin
        wb.valid = memWb.regWrite && memWb.rd != '0;
        wb.rd    = memWb.rd;
        if (memWb.linkWrite)
            wb.data = memWb.linkData;
        else if (memWb.memToReg)
            wb.data = memWb.loadData;
        else
            wb.data = memWb.aluResult;
    end

endmodule

/* pipeCore.sv */
// Five-stage RV32I core top connecting stages, register file and hazard unit
`timescale 1ns/1ps

module pipeCore (
    input  logic                       clk,
    input  logic                       reset,
    output logic [rvPipePkg::XLEN-1:0] imemAddr,
    input  logic [rvPipePkg::XLEN-1:0] imemData,
    output rvPipePkg::wbT              wb
);

    rvPipePkg::ifIdT                  ifIdIn;
    rvPipePkg::ifIdT                  ifIdOut;
    rvPipePkg::idExT                  idExIn;
    rvPipePkg::idExT                  idExOut;
    rvPipePkg::exMemT                 exMem;
    logic [rvPipePkg::REG_ADDR_W-1:0] rs1;
    logic [rvPipePkg::REG_ADDR_W-1:0] rs2;
    logic [rvPipePkg::XLEN-1:0]       rData1;
    logic [rvPipePkg::XLEN-1:0]       rData2;
    logic                             redirectValid;
    logic [rvPipePkg::XLEN-1:0]       redirectPc;
    logic                             pcStall;
    logic                             ifIdStall;
    logic                             ifIdFlush;
    logic                             idExFlush;

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .stall(pcStall),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .out(ifIdIn)
    );

    ifIdReg ifId (
        .clk(clk),
        .reset(reset),
        .stall(ifIdStall),
        .flush(ifIdFlush),
        .in(ifIdIn),
        .out(ifIdOut)
    );

    decodeUnit decode (
        .in(ifIdOut),
        .rs1(rs1),
        .rs2(rs2),
        .rData1(rData1),
        .rData2(rData2),
        .out(idExIn)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .rs1(rs1),
        .rs2(rs2),
        .rData1(rData1),
        .rData2(rData2),
        .wb(wb)
    );

    hazardUnit hazard (
        .idEx(idExOut),
        .rs1(rs1),
        .rs2(rs2),
        .redirectValid(redirectValid),
        .pcStall(pcStall),
        .ifIdStall(ifIdStall),
        .ifIdFlush(ifIdFlush),
        .idExFlush(idExFlush)
    );

    idExReg idEx (
        .clk(clk),
        .reset(reset),
        .flush(idExFlush),
        .in(idExIn),
        .out(idExOut)
    );

    executeUnit execute (
        .clk(clk),
        .reset(reset),
        .in(idExOut),
        .exMem(exMem),
        .wb(wb),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc)
    );

    memWbStage memWb (
        .clk(clk),
        .reset(reset),
        .in(exMem),
        .wb(wb)
    );

endmodule

/* coreChecks_props.sv */
// Concurrent assertions on writeback, stall and redirect behaviour, bound into pipeCore
`timescale 1ns/1ps

module coreChecks (
    input logic                       clk,
    input logic                       reset,
    input rvPipePkg::wbT              wb,
    input rvPipePkg::exMemT           exMem,
    input logic [rvPipePkg::XLEN-1:0] imemAddr,
    input logic                       pcStall,
    input logic                       redirectValid,
    input rvPipePkg::ifIdT            ifIdOut
);

    int unsigned failures = 0;
    int unsigned sinceReset; // Saturating cycle count after reset release

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            sinceReset <= 0;
        else if (sinceReset < 8)
            sinceReset <= sinceReset + 1;
    end

    // First instruction needs four edges to reach MEM/WB
    quietAfterReset: assert property (@(posedge clk) disable iff (!reset)
        sinceReset < 4 |-> !wb.valid)
        else begin
            failures++;
            $error("writeback valid before the first instruction could retire");
        end

    // Flushed NOPs and jal x0 retire without a write
    noZeroWrite: assert property (@(posedge clk) disable iff (!reset)
        exMem.regWrite && exMem.rd == '0 |=> !wb.valid)
        else begin
            failures++;
            $error("writeback for an instruction targeting x0");
        end

    stallHoldsPc: assert property (@(posedge clk) disable iff (!reset)
        pcStall |=> imemAddr == $past(imemAddr))
        else begin
            failures++;
            $error("PC moved during a stall");
        end

    redirectSquash: assert property (@(posedge clk) disable iff (!reset)
        redirectValid |=> ifIdOut.inst == rvPipePkg::NOP_INST)
        else begin
            failures++;
            $error("IF/ID not squashed after a redirect");
        end

endmodule

bind pipeCore coreChecks checks (
    .clk(clk),
    .reset(reset),
    .wb(wb),
    .exMem(exMem),
    .imemAddr(imemAddr),
    .pcStall(pcStall),
    .redirectValid(redirectValid),
    .ifIdOut(ifIdOut)
);

/* tbPipeCore.sv */
// Testbench top for pipeCore with clock generator, program ROM and expected writeback table
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

endmodule

module tbPipeCore;

    localparam int          ROM_WORDS    = 32;
    localparam int          DRAIN_CYCLES = 10;
    localparam logic [31:0] IDLE_JAL     = 32'h0000_006f; // jal x0, 0

    logic                 clk;
    logic                 reset;
    logic [31:0]          imemAddr;
    logic [31:0]          imemData;
    rvPipePkg::wbT        wb;
    logic [31:0]          prog [ROM_WORDS];
    int                   progLen;
    logic [4:0]           expRd[$];
    logic [31:0]          expData[$];
    int                   groupEnd[$];
    string                groupName[$];
    int                   ptr;
    int                   group;
    int                   groupErrors;
    int                   errors;
    int                   cycles;
    int                   cycleLimit;

    tbClock clockGen (.clk(clk));

    pipeCore UUT (
        .clk(clk),
        .reset(reset),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .wb(wb)
    );

    always_comb begin
        if (imemAddr < ROM_WORDS * 4)
            imemData = prog[imemAddr[6:2]];
        else
            imemData = IDLE_JAL;
    end

    // RV32I encoders
    function automatic logic [31:0] rOp(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic put(logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic addExpected(logic [4:0] rd, logic [31:0] data);
        expRd.push_back(rd);
        expData.push_back(data);
    endtask

    task automatic closeGroup(string name);
        groupEnd.push_back(expRd.size() - 1);
        groupName.push_back(name);
    endtask

    task automatic loadProgram();
        foreach (prog[i])
            prog[i] = IDLE_JAL;
        progLen = 0;
        put(addi(5'd1, 5'd0, 12'd5));                    // 0x00
        put(addi(5'd2, 5'd1, 12'd7));
        put(rOp(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));       // add
        put(rOp(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));       // sub
        put(rOp(7'h00, 3'b111, 5'd5, 5'd3, 5'd4));       // and
        put(rOp(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));       // or
        put(rOp(7'h00, 3'b100, 5'd7, 5'd6, 5'd3));       // xor
        put(rOp(7'h00, 3'b010, 5'd8, 5'd4, 5'd7));       // slt
        put(addi(5'd9, 5'd0, 12'hffd));                  // -3
        put(rOp(7'h00, 3'b010, 5'd10, 5'd9, 5'd4));      // signed compare
        put(sw(5'd7, 5'd0, 12'd8));                      // 0x28
        put(lw(5'd11, 5'd0, 12'd8));
        put(rOp(7'h00, 3'b000, 5'd12, 5'd11, 5'd3));     // load-use
        put(branch(3'b000, 5'd8, 5'd10, 13'd12));        // 0x34 beq to 0x40
        put(addi(5'd13, 5'd0, 12'd99));                  // skipped
        put(addi(5'd14, 5'd0, 12'd77));                  // skipped
        put(addi(5'd15, 5'd12, 12'd1));                  // 0x40
        put(addi(5'd16, 5'd0, 12'd3));
        put(addi(5'd16, 5'd16, 12'hfff));                // 0x48 loop body
        put(branch(3'b001, 5'd16, 5'd0, 13'h1ffc));      // bne back to 0x48
        put(addi(5'd17, 5'd16, 12'd10));
        put(jal(5'd18, 21'd12));                         // 0x54 to 0x60
        put(addi(5'd19, 5'd0, 12'd55));
        put(addi(5'd19, 5'd0, 12'd66));
        put(rOp(7'h00, 3'b000, 5'd20, 5'd18, 5'd17));    // 0x60
        put(IDLE_JAL);
    endtask

    // Values from RV32I semantics of the program above
    task automatic loadExpected();
        addExpected(5'd1, 32'd5);
        addExpected(5'd2, 32'd12);
        addExpected(5'd3, 32'd17);
        addExpected(5'd4, 32'd5);
        addExpected(5'd5, 32'd1);
        addExpected(5'd6, 32'd13);
        addExpected(5'd7, 32'd28);
        addExpected(5'd8, 32'd1);
        addExpected(5'd9, 32'hffff_fffd);
        addExpected(5'd10, 32'd1);
        closeGroup("ALU forwarding chain");
        addExpected(5'd11, 32'd28);
        addExpected(5'd12, 32'd45);
        closeGroup("Load-use stall");
        addExpected(5'd15, 32'd46);
        closeGroup("Forward BEQ taken");
        addExpected(5'd16, 32'd3);
        addExpected(5'd16, 32'd2);
        addExpected(5'd16, 32'd1);
        addExpected(5'd16, 32'd0);
        addExpected(5'd17, 32'd10);
        closeGroup("Backward BNE loop");
        addExpected(5'd18, 32'h58);
        addExpected(5'd20, 32'h62); // link plus x17
        closeGroup("JAL link and target");
    endtask

    task automatic checkWriteback();
        assert (wb.rd == expRd[ptr]) else begin
            $display("** Error: wb.rd = 0x%02h, expected 0x%02h (writeback %0d)",
                     wb.rd, expRd[ptr], ptr);
            errors++;
            groupErrors++;
        end
        assert (wb.data == expData[ptr]) else begin
            $display("** Error: wb.data = 0x%08h, expected 0x%08h (writeback %0d)",
                     wb.data, expData[ptr], ptr);
            errors++;
            groupErrors++;
        end
        if (ptr == groupEnd[group]) begin
            $display("%s: done, %0d mismatches", groupName[group], groupErrors);
            group++;
            groupErrors = 0;
        end
        ptr++;
    endtask

    initial begin
        reset       = 1'b0;
        ptr         = 0;
        group       = 0;
        groupErrors = 0;
        errors      = 0;
        cycles      = 0;
        loadProgram();
        loadExpected();
        cycleLimit = 4 * progLen + 40;
        repeat (5) @(negedge clk);
        reset = 1'b1;

        while (ptr < expRd.size() && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
            if (wb.valid)
                checkWriteback();
        end

        if (ptr < expRd.size()) begin
            $display("Timeout: %0d of %0d writebacks seen after %0d cycles",
                     ptr, expRd.size(), cycles);
            $display("Test failed");
        end else begin
            // Nothing may retire once the core idles
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                assert (!wb.valid) else begin
                    $display("Extra writeback to x%0d after the program ended", wb.rd);
                    errors++;
                end
            end
            $display("Checked %0d writebacks in %0d cycles: %0d errors, %0d assertion failures",
                     ptr, cycles, errors, UUT.checks.failures);
            if (errors == 0 && UUT.checks.failures == 0)
                $display("Test completed successfully");
            else
                $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
rvPipePkg.sv
pipeRegs.sv
fetchUnit.sv
decodeUnit.sv
regFile.sv
hazardUnit.sv
executeUnit.sv
memWbStage.sv
pipeCore.sv
coreChecks_props.sv
tbPipeCore.sv

/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/VtbPipeCore: vlog.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module tbPipeCore -f vlog.f

run: obj_dir/VtbPipeCore
	./obj_dir/VtbPipeCore +verilator+error+limit+100 | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tbPipeCore -f vlog.f

clean:
	rm -rf obj_dir sim.log
